//--- src.f
hdl/busPkg.sv
hdl/dmaRegs.sv
hdl/transferBuffer.sv
hdl/busMaster.sv
hdl/externalMemory.sv
hdl/serialStub.sv
hdl/memSubsystem.sv
testbench/memSubsystemTb.sv

//--- testbench/memSubsystemTb.sv
`timescale 1ns/100ps
// Directed tests for the DMA subsystem; uses the default 16-word buffer
// MMIO reads land in buffer word 0 and MMIO writes send buffer word 0
module memSubsystemTb;
    localparam int memWords = 4096;
    localparam int bufferWords = 16;
    localparam int pollLimit = 100;
    // About 15 transfers of under 40 cycles each, plus buffer traffic, is far below this
    localparam int cycleLimit = 20000;
    localparam logic [28:0] scratchWord = 29'h0000_0100;

    logic clk;
    logic reset;
    logic regWrite;
    logic regRead;
    busPkg::regIndex regAddr;
    logic [31:0] regWriteData;
    logic [31:0] regReadData;
    logic bufWrite;
    logic [$clog2(bufferWords)-1:0] bufAddr;
    logic [31:0] bufWriteData;
    logic [31:0] bufReadData;
    logic serialRxValid;
    logic [7:0] serialRxByte;
    logic serialTxValid;
    logic [7:0] serialTxByte;

    int errors = 0;
    int tests = 0;
    int cycles = 0;
    int txCount = 0;
    logic [7:0] txLast;
    logic [31:0] lcgState = 32'he0d25f12;

    memSubsystem #(.memWords(memWords), .bufferWords(bufferWords)) memSubsystem_i (
        .clk(clk), .reset(reset), .regWrite(regWrite), .regRead(regRead),
        .regAddr(regAddr), .regWriteData(regWriteData), .regReadData(regReadData),
        .bufWrite(bufWrite), .bufAddr(bufAddr), .bufWriteData(bufWriteData),
        .bufReadData(bufReadData), .serialRxValid(serialRxValid),
        .serialRxByte(serialRxByte), .serialTxValid(serialTxValid),
        .serialTxByte(serialTxByte)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        if (!reset && serialTxValid) begin
            txCount++;
            txLast = serialTxByte;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic checkStatus(input logic [31:0] got, input logic expBusy,
                               input logic expDone, input string msg);
        if (got[0] !== expBusy || got[1] !== expDone) begin
            $display("[FAIL] %0t: %s busy %b done %b expected busy %b done %b",
                     $time, msg, got[0], got[1], expBusy, expDone);
            errors++;
        end
    endtask

    task automatic writeReg(input busPkg::regIndex idx, input logic [31:0] data);
        regWrite = 1'b1;
        regAddr = idx;
        regWriteData = data;
        nextCycle();
        regWrite = 1'b0;
    endtask

    task automatic readReg(input busPkg::regIndex idx, output logic [31:0] data);
        regRead = 1'b1;
        regAddr = idx;
        nextCycle();
        regRead = 1'b0;
        data = regReadData;
    endtask

    task automatic writeBuf(input int addr, input logic [31:0] data);
        bufWrite = 1'b1;
        bufAddr = addr;
        bufWriteData = data;
        nextCycle();
        bufWrite = 1'b0;
    endtask

    task automatic readBuf(input int addr, output logic [31:0] data);
        bufAddr = addr;
        nextCycle();
        data = bufReadData;
    endtask

    task automatic waitDone();
        logic [31:0] status;
        int polls;
        status = '0;
        polls = 0;
        while (!(status[1] && !status[0]) && polls < pollLimit) begin
            readReg(busPkg::regStatus, status);
            polls++;
        end
        if (!(status[1] && !status[0])) begin
            $display("DMA transfer did not report done within %0d status polls", pollLimit);
            errors++;
        end
    endtask

    task automatic runTransfer(input logic [28:0] ext, input int bufStart, input int len,
                               input logic toMem, input logic mmio, input logic [3:0] mask);
        writeReg(busPkg::regExtAddr, 32'(ext));
        writeReg(busPkg::regBufAddr, 32'(bufStart));
        writeReg(busPkg::regLength, 32'(len));
        writeReg(busPkg::regControl, {24'b0, mask, 1'b0, mmio, toMem, 1'b1});
        // Done still shows the previous job until busy rises
        nextCycle();
        waitDone();
    endtask

    task automatic mmioRead(input logic [28:0] ext, input logic [3:0] mask,
                            output logic [31:0] data);
        runTransfer(ext, 0, 1, 1'b0, 1'b1, mask);
        readBuf(0, data);
    endtask

    task automatic mmioWrite(input logic [28:0] ext, input logic [3:0] mask,
                             input logic [31:0] data);
        writeBuf(0, data);
        runTransfer(ext, 0, 1, 1'b1, 1'b1, mask);
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        tests++;
        $display("test %s: %s", name, (errors == errorsBefore) ? "ok" : "mismatch");
    endtask

    task automatic testReset();
        logic [31:0] status;
        int startErrors;
        startErrors = errors;
        readReg(busPkg::regStatus, status);
        checkStatus(status, 1'b0, 1'b0, "status after reset");
        if (txCount != 0) begin
            $display("serialTxValid pulsed after reset without any transfer");
            errors++;
        end
        reportTest("reset", startErrors);
    endtask

    task automatic testFullBurst();
        logic [31:0] orig [bufferWords];
        logic [31:0] got;
        int startErrors;
        startErrors = errors;
        for (int i = 0; i < bufferWords; i++) begin
            orig[i] = nextRandom();
            writeBuf(i, orig[i]);
        end
        runTransfer(29'h0000_0040, 0, bufferWords, 1'b1, 1'b0, 4'b0000);
        for (int i = 0; i < bufferWords; i++) begin
            writeBuf(i, 32'h0);
        end
        runTransfer(29'h0000_0040, 0, bufferWords, 1'b0, 1'b0, 4'b0000);
        for (int i = 0; i < bufferWords; i++) begin
            readBuf(i, got);
            checkWord(got, orig[i], $sformatf("full burst word %0d", i));
        end
        reportTest("fullBurst", startErrors);
    endtask

    task automatic testPartialBursts();
        logic [31:0] orig [bufferWords];
        logic [31:0] expected [bufferWords];
        logic [31:0] got;
        int startErrors;
        startErrors = errors;
        for (int i = 0; i < bufferWords; i++) begin
            orig[i] = nextRandom();
            writeBuf(i, orig[i]);
        end
        runTransfer(29'h0000_0200, 3, 5, 1'b1, 1'b0, 4'b0000);
        runTransfer(29'h0000_0300, 10, 1, 1'b1, 1'b0, 4'b0000);
        // New background so stray writes show up
        for (int i = 0; i < bufferWords; i++) begin
            expected[i] = nextRandom();
            writeBuf(i, expected[i]);
        end
        runTransfer(29'h0000_0200, 7, 5, 1'b0, 1'b0, 4'b0000);
        runTransfer(29'h0000_0300, 1, 1, 1'b0, 1'b0, 4'b0000);
        for (int i = 0; i < 5; i++) begin
            expected[7 + i] = orig[3 + i];
        end
        expected[1] = orig[10];
        for (int i = 0; i < bufferWords; i++) begin
            readBuf(i, got);
            checkWord(got, expected[i], $sformatf("partial burst buffer word %0d", i));
        end
        reportTest("partialBursts", startErrors);
    endtask

    task automatic testSerialTx();
        logic [31:0] word;
        int startErrors;
        startErrors = errors;
        word = nextRandom() | 32'h80;
        txCount = 0;
        mmioWrite(busPkg::serialDataWord, 4'b0001, word);
        nextCycle();
        if (txCount != 1) begin
            $display("serial transmit produced %0d pulses instead of one", txCount);
            errors++;
        end
        checkByte(txLast, {1'b0, word[6:0]}, "transmitted byte");
        reportTest("serialTx", startErrors);
    endtask

    task automatic testSerialRx();
        logic [31:0] rnd;
        logic [31:0] got;
        int startErrors;
        startErrors = errors;
        rnd = nextRandom();
        serialRxValid = 1'b1;
        serialRxByte = rnd[7:0];
        nextCycle();
        serialRxValid = 1'b0;
        mmioRead(busPkg::serialStatusWord, 4'b0010, got);
        checkWord(got, 32'h6100, "status with byte held");
        mmioRead(busPkg::serialDataWord, 4'b0001, got);
        checkByte(got[7:0], rnd[7:0], "received byte");
        mmioRead(busPkg::serialStatusWord, 4'b0010, got);
        checkWord(got, 32'h6000, "status after byte taken");
        mmioRead(busPkg::serialDataWord, 4'b0001, got);
        checkWord(got, 32'h0, "data read with nothing held");
        reportTest("serialRx", startErrors);
    endtask

    task automatic testScratch();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] got;
        int startErrors;
        startErrors = errors;
        first = nextRandom();
        second = nextRandom();
        mmioWrite(scratchWord, 4'b1111, first);
        mmioWrite(scratchWord, 4'b0100, second);
        mmioRead(scratchWord, 4'b1111, got);
        checkWord(got, {first[31:24], second[23:16], first[15:0]}, "scratch word");
        reportTest("scratch", startErrors);
    endtask

    initial begin
        reset = 1'b1;
        regWrite = 1'b0;
        regRead = 1'b0;
        regAddr = busPkg::regExtAddr;
        regWriteData = '0;
        bufWrite = 1'b0;
        bufAddr = '0;
        bufWriteData = '0;
        serialRxValid = 1'b0;
        serialRxByte = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        nextCycle();
        testReset();
        testFullBurst();
        testPartialBursts();
        testSerialTx();
        testSerialRx();
        testScratch();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/memSubsystem.sv
`timescale 1ns/100ps
// DMA subsystem top; memWords must be a power of two
module memSubsystem #(
    parameter int memWords = 4096,
    parameter int bufferWords = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic regWrite,
    input  logic regRead,
    input  busPkg::regIndex regAddr,
    input  logic [31:0] regWriteData,
    output logic [31:0] regReadData,
    input  logic bufWrite,
    input  logic [$clog2(bufferWords)-1:0] bufAddr,
    input  logic [31:0] bufWriteData,
    output logic [31:0] bufReadData,
    input  logic serialRxValid,
    input  logic [7:0] serialRxByte,
    output logic serialTxValid,
    output logic [7:0] serialTxByte
);
    localparam int addrWidth = $clog2(bufferWords);

    logic [28:0] extAddr;
    logic [addrWidth-1:0] bufStart;
    logic [addrWidth:0] xferLength;
    busPkg::xferDir direction;
    logic mmioSel;
    logic [3:0] byteMask;
    logic startPulse;
    logic xferDone;
    logic [addrWidth-1:0] dmaAddr;
    logic dmaWrite;
    logic [31:0] dmaWriteData;
    logic [31:0] dmaReadData;
    logic busEn;
    logic [31:0] busOut;
    logic [31:0] busIn;
    logic busOen;
    logic busStall;
    logic txStrobe;
    logic [7:0] txByte;
    logic rxTake;
    logic rxAvail;
    logic [7:0] rxByte;

    // Busy is seen by the host through the status register
    dmaRegs #(.bufferWords(bufferWords)) dmaRegs_i (
        .clk(clk), .reset(reset), .regWrite(regWrite), .regRead(regRead),
        .regAddr(regAddr), .regWriteData(regWriteData), .xferDone(xferDone),
        .regReadData(regReadData), .extAddr(extAddr), .bufStart(bufStart),
        .xferLength(xferLength), .direction(direction), .mmioSel(mmioSel),
        .byteMask(byteMask), .startPulse(startPulse), .busy()
    );

    transferBuffer #(.bufferWords(bufferWords)) transferBuffer_i (
        .clk(clk), .hostWrite(bufWrite), .hostAddr(bufAddr), .hostWriteData(bufWriteData),
        .dmaWrite(dmaWrite), .dmaAddr(dmaAddr), .dmaWriteData(dmaWriteData),
        .hostReadData(bufReadData), .dmaReadData(dmaReadData)
    );

    busMaster #(.bufferWords(bufferWords)) busMaster_i (
        .clk(clk), .reset(reset), .startPulse(startPulse), .extAddr(extAddr),
        .bufStart(bufStart), .xferLength(xferLength), .direction(direction),
        .mmioSel(mmioSel), .byteMask(byteMask), .dmaReadData(dmaReadData),
        .busIn(busIn), .busOen(busOen), .busStall(busStall), .dmaAddr(dmaAddr),
        .dmaWrite(dmaWrite), .dmaWriteData(dmaWriteData), .xferDone(xferDone),
        .busEn(busEn), .busOut(busOut)
    );

    externalMemory #(.memWords(memWords)) externalMemory_i (
        .clk(clk), .reset(reset), .busEn(busEn), .busOut(busOut),
        .rxAvail(rxAvail), .rxByte(rxByte), .busIn(busIn), .busOen(busOen),
        .busStall(busStall), .txStrobe(txStrobe), .txByte(txByte), .rxTake(rxTake)
    );

    serialStub serialStub_i (
        .clk(clk), .reset(reset), .serialRxValid(serialRxValid),
        .serialRxByte(serialRxByte), .rxTake(rxTake), .txStrobe(txStrobe),
        .txByte(txByte), .rxAvail(rxAvail), .rxByte(rxByte),
        .serialTxValid(serialTxValid), .serialTxByte(serialTxByte)
    );

endmodule

//--- hdl/serialStub.sv
`timescale 1ns/100ps
// Minimal serial port; one held receive byte, a new byte overwrites it
module serialStub (
    input  logic clk,
    input  logic reset,
    input  logic serialRxValid,
    input  logic [7:0] serialRxByte,
    input  logic rxTake,
    input  logic txStrobe,
    input  logic [7:0] txByte,
    output logic rxAvail,
    output logic [7:0] rxByte,
    output logic serialTxValid,
    output logic [7:0] serialTxByte
);

    always_ff @(posedge clk) begin
        if (reset) begin
            rxAvail <= 1'b0;
            serialTxValid <= 1'b0;
        end else begin
            serialTxValid <= txStrobe;
            // Incoming byte wins over a take in the same cycle
            if (serialRxValid) begin
                rxAvail <= 1'b1;
            end else if (rxTake) begin
                rxAvail <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (serialRxValid) begin
            rxByte <= serialRxByte;
        end
        serialTxByte <= txByte;
    end

endmodule

//--- hdl/externalMemory.sv
`timescale 1ns/100ps
// External memory model; reads take one stall cycle, MMIO reads reply next cycle
// memWords must be a power of two and addresses wrap at that size
module externalMemory #(
    parameter int memWords = 4096
) (
    input  logic clk,
    input  logic reset,
    input  logic busEn,
    input  logic [31:0] busOut,
    input  logic rxAvail,
    input  logic [7:0] rxByte,
    output logic [31:0] busIn,
    output logic busOen,
    output logic busStall,
    output logic txStrobe,
    output logic [7:0] txByte,
    output logic rxTake
);
    localparam int memAddrWidth = $clog2(memWords);
    localparam int maskLsb = busPkg::busMaskLsb;

    logic [31:0] mem [memWords];
    busPkg::memState state;
    logic [28:0] addr;
    logic isMem;
    logic [3:0] mask;
    logic [31:0] scratch;
    logic mmioReadCmd;
    logic [3:0] cmdMask;

    assign cmdMask = busOut[maskLsb +: 4];
    assign mmioReadCmd = busEn && !busOut[busPkg::busWriteBit] && !busOut[busPkg::busMemBit];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= busPkg::memIdle;
            busOen <= 1'b0;
            busStall <= 1'b0;
            txStrobe <= 1'b0;
            rxTake <= 1'b0;
        end else begin
            busStall <= 1'b0;
            txStrobe <= 1'b0;
            rxTake <= 1'b0;
            case (state)
                busPkg::memIdle: begin
                    busOen <= mmioReadCmd;
                    if (busEn) begin
                        addr <= busOut[28:0];
                        isMem <= busOut[busPkg::busMemBit];
                        mask <= cmdMask;
                    end
                    if (busEn && busOut[busPkg::busWriteBit]) begin
                        state <= busPkg::memWrite;
                    end else if (busEn && busOut[busPkg::busMemBit]) begin
                        // One stall cycle before the first read word
                        state <= busPkg::memRead;
                        busOen <= 1'b1;
                        busStall <= 1'b1;
                    end else if (mmioReadCmd) begin
                        if (cmdMask == 4'b0001 && busOut[maskLsb-1:0]
                            == busPkg::serialDataWord[maskLsb-1:0]) begin
                            busIn <= {24'b0, rxAvail ? rxByte : 8'h00};
                            rxTake <= rxAvail;
                        end else if (cmdMask == 4'b0010 && busOut[maskLsb-1:0]
                            == busPkg::serialStatusWord[maskLsb-1:0]) begin
                            busIn <= busPkg::serialStatusIdle
                                     | (rxAvail ? busPkg::serialStatusRxAvail : 32'h0);
                        end else begin
                            busIn <= scratch;
                        end
                    end
                end
                busPkg::memWrite: begin
                    if (!busEn) begin
                        state <= busPkg::memIdle;
                    end else if (isMem) begin
                        mem[addr[memAddrWidth-1:0]] <= busOut;
                        addr <= addr + 1'b1;
                    end else if (mask == 4'b0001 && addr[maskLsb-1:0]
                                 == busPkg::serialDataWord[maskLsb-1:0]) begin
                        txStrobe <= 1'b1;
                        txByte <= {1'b0, busOut[6:0]};
                    end else begin
                        for (int i = 0; i < 4; i++) begin
                            if (mask[i]) begin
                                scratch[8*i +: 8] <= busOut[8*i +: 8];
                            end
                        end
                    end
                end
                busPkg::memRead: begin
                    busOen <= busEn;
                    if (busEn) begin
                        busIn <= mem[addr[memAddrWidth-1:0]];
                        addr <= addr + 1'b1;
                    end else begin
                        state <= busPkg::memIdle;
                    end
                end
                default: state <= busPkg::memIdle;
            endcase
        end
    end

    // In idle, only the cycle after an MMIO read command may drive data
    assert property (@(posedge clk) disable iff (reset)
        (state == busPkg::memIdle && !$past(state == busPkg::memIdle && mmioReadCmd))
        |-> !busOen);

endmodule

//--- hdl/busMaster.sv
`timescale 1ns/100ps
// DMA bus master; one command word per transfer, then a data burst
// MMIO transfers are always a single word regardless of the length setting
module busMaster #(
    parameter int bufferWords = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic startPulse,
    input  logic [28:0] extAddr,
    input  logic [$clog2(bufferWords)-1:0] bufStart,
    input  logic [$clog2(bufferWords):0] xferLength,
    input  busPkg::xferDir direction,
    input  logic mmioSel,
    input  logic [3:0] byteMask,
    input  logic [31:0] dmaReadData,
    input  logic [31:0] busIn,
    input  logic busOen,
    input  logic busStall,
    output logic [$clog2(bufferWords)-1:0] dmaAddr,
    output logic dmaWrite,
    output logic [31:0] dmaWriteData,
    output logic xferDone,
    output logic busEn,
    output logic [31:0] busOut
);
    localparam int addrWidth = $clog2(bufferWords);

    busPkg::masterState state;
    logic isWrite;
    logic isMmio;
    logic [31:0] command;
    logic [31:0] commandNext;
    logic [addrWidth:0] wordCount;
    logic [addrWidth:0] reqLeft;
    logic [addrWidth:0] rcvLeft;
    logic wordValid;

    always_comb begin
        commandNext = '0;
        commandNext[busPkg::busWriteBit] = (direction == busPkg::dirWrite);
        commandNext[busPkg::busMemBit] = !mmioSel;
        if (mmioSel) begin
            commandNext[busPkg::busMaskLsb +: 4] = byteMask;
            commandNext[busPkg::busMaskLsb-1:0] = extAddr[busPkg::busMaskLsb-1:0];
        end else begin
            commandNext[busPkg::busMemBit-1:0] = extAddr;
        end
    end

    assign wordCount = mmioSel ? (addrWidth + 1)'(1) : xferLength;
    assign wordValid = busOen && !busStall;

    // Received words go straight into the buffer at the running pointer
    assign dmaWrite = (state == busPkg::msReadData) && wordValid;
    assign dmaWriteData = busIn;

    // Write data is the buffer word prefetched in the previous cycle
    assign busOut = (state == busPkg::msWriteData) ? dmaReadData : command;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= busPkg::msIdle;
            busEn <= 1'b0;
            xferDone <= 1'b0;
        end else begin
            xferDone <= 1'b0;
            case (state)
                busPkg::msIdle: begin
                    if (startPulse) begin
                        busEn <= 1'b1;
                        state <= busPkg::msCommand;
                    end
                end
                busPkg::msCommand: begin
                    // MMIO read reply needs no further requests
                    if (isMmio && !isWrite) begin
                        busEn <= 1'b0;
                    end
                    state <= isWrite ? busPkg::msWriteData : busPkg::msReadData;
                end
                busPkg::msWriteData: begin
                    if (reqLeft == 1) begin
                        busEn <= 1'b0;
                        state <= busPkg::msGap;
                    end
                end
                busPkg::msReadData: begin
                    if (busEn && reqLeft == 1) begin
                        busEn <= 1'b0;
                    end
                    if (wordValid && rcvLeft == 1) begin
                        state <= busPkg::msGap;
                    end
                end
                busPkg::msGap: begin
                    xferDone <= 1'b1;
                    state <= busPkg::msIdle;
                end
                default: state <= busPkg::msIdle;
            endcase
        end
    end

    // Transfer settings and counters
    always_ff @(posedge clk) begin
        if (state == busPkg::msIdle && startPulse) begin
            command <= commandNext;
            isWrite <= (direction == busPkg::dirWrite);
            isMmio <= mmioSel;
            dmaAddr <= bufStart;
            reqLeft <= wordCount;
            rcvLeft <= wordCount;
        end
        if (busEn && reqLeft != 1
            && (state == busPkg::msWriteData || state == busPkg::msReadData)) begin
            reqLeft <= reqLeft - 1'b1;
        end
        if (dmaWrite) begin
            rcvLeft <= rcvLeft - 1'b1;
        end
        if (dmaWrite || (isWrite
            && (state == busPkg::msCommand || state == busPkg::msWriteData))) begin
            dmaAddr <= dmaAddr + 1'b1;
        end
    end

    // The memory decodes a command on the first busEn cycle, so it needs an idle cycle
    assert property (@(posedge clk) disable iff (reset) $fell(busEn) |=> !busEn);

endmodule

//--- hdl/transferBuffer.sv
`timescale 1ns/100ps
// Two-port word RAM with registered reads on both ports
// Same-word writes from both ports in one edge keep the DMA data
module transferBuffer #(
    parameter int bufferWords = 16
) (
    input  logic clk,
    input  logic hostWrite,
    input  logic [$clog2(bufferWords)-1:0] hostAddr,
    input  logic [31:0] hostWriteData,
    input  logic dmaWrite,
    input  logic [$clog2(bufferWords)-1:0] dmaAddr,
    input  logic [31:0] dmaWriteData,
    output logic [31:0] hostReadData,
    output logic [31:0] dmaReadData
);
    logic [31:0] words [bufferWords];

    always_ff @(posedge clk) begin
        if (hostWrite) begin
            words[hostAddr] <= hostWriteData;
        end
        // Later assignment gives the DMA port priority
        if (dmaWrite) begin
            words[dmaAddr] <= dmaWriteData;
        end
        hostReadData <= words[hostAddr];
        dmaReadData <= words[dmaAddr];
    end

endmodule

//--- hdl/dmaRegs.sv
`timescale 1ns/100ps
// Host register block; settings are sampled by the master at start
// A start while busy is dropped and a zero length is stored as one
module dmaRegs #(
    parameter int bufferWords = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic regWrite,
    input  logic regRead,
    input  busPkg::regIndex regAddr,
    input  logic [31:0] regWriteData,
    input  logic xferDone,
    output logic [31:0] regReadData,
    output logic [28:0] extAddr,
    output logic [$clog2(bufferWords)-1:0] bufStart,
    output logic [$clog2(bufferWords):0] xferLength,
    output busPkg::xferDir direction,
    output logic mmioSel,
    output logic [3:0] byteMask,
    output logic startPulse,
    output logic busy
);
    localparam int addrWidth = $clog2(bufferWords);

    logic done;
    logic [addrWidth:0] lengthField;

    assign lengthField = regWriteData[addrWidth:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            extAddr <= '0;
            bufStart <= '0;
            xferLength <= (addrWidth + 1)'(1);
            direction <= busPkg::dirRead;
            mmioSel <= 1'b0;
            byteMask <= 4'b0000;
        end else if (regWrite) begin
            case (regAddr)
                busPkg::regExtAddr: extAddr <= regWriteData[28:0];
                busPkg::regBufAddr: bufStart <= regWriteData[addrWidth-1:0];
                busPkg::regLength: begin
                    xferLength <= (lengthField == '0) ? (addrWidth + 1)'(1) : lengthField;
                end
                busPkg::regControl: begin
                    direction <= busPkg::xferDir'(regWriteData[1]);
                    mmioSel <= regWriteData[2];
                    byteMask <= regWriteData[7:4];
                end
                default: ;
            endcase
        end
    end

    // Start, busy and done
    always_ff @(posedge clk) begin
        if (reset) begin
            startPulse <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            startPulse <= regWrite && regAddr == busPkg::regControl && regWriteData[0]
                          && !busy && !startPulse;
            if (startPulse) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (xferDone) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (regRead) begin
            case (regAddr)
                busPkg::regExtAddr: regReadData <= {3'b000, extAddr};
                busPkg::regBufAddr: regReadData <= 32'(bufStart);
                busPkg::regLength: regReadData <= 32'(xferLength);
                busPkg::regControl: regReadData <= {24'b0, byteMask, 1'b0, mmioSel, direction, 1'b0};
                busPkg::regStatus: regReadData <= {30'b0, done, busy};
                default: regReadData <= '0;
            endcase
        end
    end

    // Busy only falls on the master's done, so a job never starts on top of another
    assert property (@(posedge clk) disable iff (reset) startPulse |-> !busy);

endmodule

//--- hdl/busPkg.sv
// Bus command fields, MMIO map and state types shared by the DMA subsystem
// MMIO word addresses must fit below the byte mask field, which starts at bit 25
package busPkg;

    // Command word fields
    parameter int busWriteBit = 31;
    parameter int busMemBit = 29;
    parameter int busMaskLsb = 25;

    // Serial stub registers in MMIO space
    parameter logic [28:0] serialDataWord = 29'h0040_0000;
    parameter logic [28:0] serialStatusWord = serialDataWord + 29'd1;
    parameter logic [31:0] serialStatusIdle = 32'h0000_6000;
    parameter logic [31:0] serialStatusRxAvail = 32'h0000_0100;

    typedef enum logic [2:0] {
        regExtAddr,
        regBufAddr,
        regLength,
        regControl,
        regStatus
    } regIndex;

    typedef enum logic {
        dirRead,
        dirWrite
    } xferDir;

    typedef enum logic [2:0] {
        msIdle,
        msCommand,
        msWriteData,
        msReadData,
        msGap
    } masterState;

    typedef enum logic [1:0] {
        memIdle,
        memWrite,
        memRead
    } memState;

endpackage
